/* hdl/hps_io_pkg.sv */
package hps_io_pkg;

	// host command codes, first word of each transfer
	localparam logic [7:0] cmd_buttons  = 8'h01;
	localparam logic [7:0] cmd_joy0     = 8'h02;
	localparam logic [7:0] cmd_joy1     = 8'h03;
	localparam logic [7:0] cmd_mouse    = 8'h04;
	localparam logic [7:0] cmd_kbd      = 8'h05;
	localparam logic [7:0] cmd_osd      = 8'h06;
	localparam logic [7:0] cmd_rtc      = 8'h22;
	localparam logic [7:0] cmd_vid_info = 8'h23;

	// event FIFO depth between decoder and output stage
	localparam int fifo_depth = 4;

	typedef enum logic [1:0] {
		mouse_x = 2'd0,
		mouse_y = 2'd1,
		keycode = 2'd2,
		osd_key = 2'd3
	} ev_kind_t;

	typedef struct packed {
		ev_kind_t   kind;
		logic [7:0] data;
	} input_event_t;

	typedef struct packed {
		logic [7:0]  nres;  // resolution change count
		logic [31:0] hcnt;  // active pixels per line
		logic [31:0] vcnt;  // active lines per frame
		logic [31:0] htime; // clocks per line
		logic [31:0] vtime; // clocks per frame
	} vid_info_t;

endpackage

/* hdl/hps_io_top.sv */
`timescale 1ns/100ps

module hps_io_top
	import hps_io_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        io_ena,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	output logic [15:0] io_dout,
	output logic        io_wait,
	input  logic        ce_pix,
	input  logic        de,
	input  logic        hs,
	input  logic        vs,
	output logic [15:0] joy0,
	output logic [15:0] joy1,
	output logic [1:0]  buttons,
	output logic [3:0]  conf,
	output logic [2:0]  mouse_buttons,
	output logic        kbd_strobe,
	output logic        kbd_level,
	output ev_kind_t    kbd_type,
	output logic [7:0]  kbd_data,
	input  logic        kbd_hold,
	output logic [63:0] rtc
);

	vid_info_t vid;

	input_event_if ev_in(.clk(clk));  // decoder to FIFO
	input_event_if ev_out(.clk(clk)); // FIFO to output stage

	user_io u_user_io (
		.clk, .rst, .io_ena, .io_strobe, .io_din, .io_dout, .io_wait,
		.vid, .ev(ev_in.source),
		.joy0, .joy1, .buttons, .conf, .mouse_buttons, .rtc
	);

	input_event_fifo u_fifo (.clk, .rst, .push(ev_in.sink), .pop(ev_out.source));

	input_event_out u_out (
		.clk, .rst, .ev(ev_out.sink), .kbd_hold,
		.kbd_strobe, .kbd_level, .kbd_type, .kbd_data
	);

	video_meter u_meter (.clk, .rst, .ce_pix, .de, .hs, .vs, .vid);

endmodule

/* hdl/input_event_fifo.sv */
`timescale 1ns/100ps

module input_event_fifo
	import hps_io_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input_event_if.sink   push,
	input_event_if.source pop
);

	localparam int aw = $clog2(fifo_depth);

	input_event_t                  mem [fifo_depth];
	logic [aw-1:0]                 wr_ptr;
	logic [aw-1:0]                 rd_ptr;
	logic [$clog2(fifo_depth+1)-1:0] count;
	logic                          do_push;
	logic                          do_pop;

	assign push.ready = (count != fifo_depth);
	assign pop.valid  = (count != 0);
	assign pop.data   = mem[rd_ptr];

	assign do_push = push.valid & push.ready;
	assign do_pop  = pop.valid & pop.ready;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push.data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // both or neither, level unchanged
			endcase
		end
	end

	// count stays in range and in step with the pointer distance
	count_in_range: assert property (@(posedge clk) disable iff (rst)
		count <= fifo_depth &&
		(count % fifo_depth) == ((wr_ptr + fifo_depth - rd_ptr) % fifo_depth))
		else $error("event FIFO count out of range or out of step with pointers");

	// pointers must show a stored item whenever one leaves
	no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
		do_pop |-> wr_ptr != rd_ptr || count == fifo_depth)
		else $error("pop from empty event FIFO");

endmodule

/* hdl/input_event_if.sv */
`timescale 1ns/100ps

interface input_event_if
	import hps_io_pkg::*;
(
	input logic clk
);
	logic         valid;
	logic         ready;
	input_event_t data;

	modport source(input clk, input ready, output valid, output data);
	modport sink(input clk, input valid, input data, output ready);

	// a stalled item stays put until the sink takes it
	hold_while_stalled: assert property (@(posedge clk)
		valid && !ready |=> valid && $stable(data))
		else $error("event changed or dropped while stalled");

endinterface

/* hdl/input_event_out.sv */
`timescale 1ns/100ps

module input_event_out
	import hps_io_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input_event_if.sink ev,
	input  logic        kbd_hold,
	output logic        kbd_strobe,
	output logic        kbd_level,
	output ev_kind_t    kbd_type,
	output logic [7:0]  kbd_data
);

	logic take;

	// one event per strobe, core can pause us with kbd_hold
	assign ev.ready = ~kbd_hold & ~kbd_strobe;
	assign take     = ev.valid & ev.ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			kbd_strobe <= 1'b0;
			kbd_level  <= 1'b0;
			kbd_type   <= mouse_x;
			kbd_data   <= '0;
		end else begin
			kbd_strobe <= take;
			if (take) begin
				kbd_level <= ~kbd_level; // level flips once per event
				kbd_type  <= ev.data.kind;
				kbd_data  <= ev.data.data;
			end
		end
	end

	single_cycle_strobe: assert property (@(posedge clk) disable iff (rst)
		kbd_strobe |=> !kbd_strobe)
		else $error("kbd_strobe high on consecutive cycles");

endmodule

/* hdl/user_io.sv */
`timescale 1ns/100ps

module user_io
	import hps_io_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          io_ena,
	input  logic          io_strobe,
	input  logic [15:0]   io_din,
	output logic [15:0]   io_dout,
	output logic          io_wait,
	input  vid_info_t     vid,
	input_event_if.source ev,
	output logic [15:0]   joy0,
	output logic [15:0]   joy1,
	output logic [1:0]    buttons,
	output logic [3:0]    conf,
	output logic [2:0]    mouse_buttons,
	output logic [63:0]   rtc
);

	logic [3:0]   cnt; // word index within transfer, saturates
	logic [7:0]   cmd;
	logic         ev_valid;
	input_event_t ev_data;

	assign ev.valid = ev_valid;
	assign ev.data  = ev_data;

	// stall the host while an event waits on a full FIFO
	assign io_wait = ev_valid & ~ev.ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt           <= '0;
			cmd           <= '0;
			ev_valid      <= 1'b0;
			ev_data       <= '0;
			io_dout       <= '0;
			joy0          <= '0;
			joy1          <= '0;
			buttons       <= '0;
			conf          <= '0;
			mouse_buttons <= '0;
			rtc           <= '0;
		end else begin
			if (ev_valid && ev.ready)
				ev_valid <= 1'b0; // taken by the FIFO

			if (!io_ena) begin
				cnt <= '0;
			end else if (io_strobe) begin
				if (cnt != 4'hf)
					cnt <= cnt + 4'd1;

				if (cnt == 4'd0)
					cmd <= io_din[7:0];

				// first payload word
				if (cnt == 4'd1) begin
					case (cmd)
						cmd_buttons: begin
							buttons <= io_din[1:0];
							conf    <= io_din[7:4];
						end
						cmd_joy0: joy0 <= io_din;
						cmd_joy1: joy1 <= io_din;
						cmd_mouse: begin
							ev_valid <= 1'b1;
							ev_data  <= '{kind: mouse_x, data: io_din[7:0]};
						end
						cmd_kbd: begin
							ev_valid <= 1'b1;
							ev_data  <= '{kind: keycode, data: io_din[7:0]};
						end
						cmd_osd: begin
							ev_valid <= 1'b1;
							ev_data  <= '{kind: osd_key, data: io_din[7:0]};
						end
						default: ;
					endcase
				end

				if (cmd == cmd_mouse && cnt == 4'd2) begin
					ev_valid <= 1'b1;
					ev_data  <= '{kind: mouse_y, data: io_din[7:0]};
				end
				if (cmd == cmd_mouse && cnt == 4'd3)
					mouse_buttons <= io_din[2:0];

				// words 1..4 fill rtc from the low end
				if (cmd == cmd_rtc && cnt >= 4'd1 && cnt <= 4'd4)
					rtc[{cnt[1:0] - 2'd1, 4'h0} +: 16] <= io_din;

				if (cmd == cmd_vid_info) begin
					case (cnt)
						4'd1: io_dout <= {8'h00, vid.nres};
						4'd2: io_dout <= vid.hcnt[15:0];
						4'd3: io_dout <= vid.hcnt[31:16];
						4'd4: io_dout <= vid.vcnt[15:0];
						4'd5: io_dout <= vid.vcnt[31:16];
						4'd6: io_dout <= vid.htime[15:0];
						4'd7: io_dout <= vid.htime[31:16];
						4'd8: io_dout <= vid.vtime[15:0];
						4'd9: io_dout <= vid.vtime[31:16];
						default: ;
					endcase
				end
			end
		end
	end

	// host side of the bus must honour io_wait
	no_strobe_in_wait: assert property (@(posedge clk) disable iff (rst)
		io_strobe |-> !io_wait)
		else $error("host strobe while io_wait is high");

endmodule

/* hdl/video_meter.sv */
`timescale 1ns/100ps

module video_meter
	import hps_io_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      ce_pix,
	input  logic      de,
	input  logic      hs,
	input  logic      vs,
	output vid_info_t vid
);

	logic        old_vs_p, old_de_p;
	logic        calch; // still on first active line
	logic [31:0] hcnt, vcnt;
	logic [31:0] hcnt_q, vcnt_q;
	logic [7:0]  nres;

	logic        old_hs_c, old_vs_c;
	logic [31:0] htime_cnt, vtime_cnt;
	logic [31:0] htime_q, vtime_q;

	assign vid = '{nres: nres, hcnt: hcnt_q, vcnt: vcnt_q, htime: htime_q, vtime: vtime_q};

	// active area, sampled at pixel rate
	always_ff @(posedge clk) begin
		if (rst) begin
			old_vs_p <= 1'b0;
			old_de_p <= 1'b0;
			calch    <= 1'b0;
			hcnt     <= '0;
			vcnt     <= '0;
			hcnt_q   <= '0;
			vcnt_q   <= '0;
			nres     <= '0;
		end else if (ce_pix) begin
			old_vs_p <= vs;
			old_de_p <= de;

			if (!vs && !old_de_p && de)
				vcnt <= vcnt + 32'd1; // new active line
			if (calch && de)
				hcnt <= hcnt + 32'd1;
			if (old_de_p && !de)
				calch <= 1'b0;

			// end of vsync closes the frame
			if (old_vs_p && !vs) begin
				if (hcnt != 0 && vcnt != 0) begin
					if (hcnt_q != hcnt || vcnt_q != vcnt)
						nres <= nres + 8'd1;
					hcnt_q <= hcnt;
					vcnt_q <= vcnt;
				end
				hcnt  <= '0;
				vcnt  <= '0;
				calch <= 1'b1;
			end
		end
	end

	// line and frame periods in clk cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			old_hs_c  <= 1'b0;
			old_vs_c  <= 1'b0;
			htime_cnt <= '0;
			vtime_cnt <= '0;
			htime_q   <= '0;
			vtime_q   <= '0;
		end else begin
			old_hs_c  <= hs;
			old_vs_c  <= vs;
			htime_cnt <= htime_cnt + 32'd1;
			vtime_cnt <= vtime_cnt + 32'd1;

			if (hs && !old_hs_c) begin
				htime_q   <= htime_cnt;
				htime_cnt <= 32'd1; // edge cycle counts as first clock
			end
			if (vs && !old_vs_c) begin
				vtime_q   <= vtime_cnt;
				vtime_cnt <= 32'd1;
			end
		end
	end

endmodule

/* list.f */
hdl/hps_io_pkg.sv
hdl/input_event_if.sv
hdl/user_io.sv
hdl/input_event_fifo.sv
hdl/input_event_out.sv
hdl/video_meter.sv
hdl/hps_io_top.sv
tests/hps_io_checker.sv
tests/tb_hps_io.sv

/* run.sh */
#!/bin/bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hps_io -f list.f \
	&& ./obj_dir/Vtb_hps_io | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }
grep -qx "Verification passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* tests/hps_io_checker.sv */
`timescale 1ns/100ps

module hps_io_checker
	import hps_io_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        io_ena,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	input  logic [15:0] io_dout,
	input  logic [15:0] joy0,
	input  logic [15:0] joy1,
	input  logic [1:0]  buttons,
	input  logic [3:0]  conf,
	input  logic [2:0]  mouse_buttons,
	input  logic [63:0] rtc,
	input  logic        kbd_strobe,
	input  logic        kbd_level,
	input  ev_kind_t    kbd_type,
	input  logic [7:0]  kbd_data,
	input  vid_info_t   exp_vid,
	input  logic        test_end,
	input  int          test_id,
	input  logic        done,
	input  int          wait_fails,
	output int          errors,
	output int          pending
);

	typedef struct packed {
		logic [7:0]   cmd;
		logic [15:0]  joy0;
		logic [15:0]  joy1;
		logic [1:0]   buttons;
		logic [3:0]   conf;
		logic [2:0]   mouse_buttons;
		logic [63:0]  rtc;
		logic [15:0]  dout;
		logic         ev_new; // this word produced an event
		input_event_t ev;
	} ref_state_t;

	ref_state_t   st;
	input_event_t exp_q[$]; // events still owed by the DUT
	input_event_t got;
	logic         level;
	int           idx;
	int           bad;
	int           err_total = 0;
	int           err_test = 0;
	int           fails_seen = 0;
	int           tests_run = 0;
	int           tests_bad = 0;

	// expected state after host word idx of the current transfer
	function automatic ref_state_t apply_word(ref_state_t s, int idx, logic [15:0] w,
		vid_info_t v);
		ref_state_t   r;
		logic [127:0] meas;
		r = s;
		r.ev_new = 1'b0;
		meas = {v.vtime, v.htime, v.vcnt, v.hcnt};
		if (idx == 0) begin
			r.cmd = w[7:0];
		end else begin
			case (s.cmd)
				cmd_buttons: if (idx == 1) begin
					r.buttons = w[1:0];
					r.conf    = w[7:4];
				end
				cmd_joy0: if (idx == 1) r.joy0 = w;
				cmd_joy1: if (idx == 1) r.joy1 = w;
				cmd_kbd: if (idx == 1) r.ev = '{kind: keycode, data: w[7:0]};
				cmd_osd: if (idx == 1) r.ev = '{kind: osd_key, data: w[7:0]};
				cmd_mouse: begin
					if (idx == 1) r.ev = '{kind: mouse_x, data: w[7:0]};
					if (idx == 2) r.ev = '{kind: mouse_y, data: w[7:0]};
					if (idx == 3) r.mouse_buttons = w[2:0];
				end
				cmd_rtc: if (idx <= 4) r.rtc[16 * (idx - 1) +: 16] = w;
				cmd_vid_info: begin
					if (idx == 1) r.dout = {8'h00, v.nres};
					else if (idx <= 9) r.dout = meas[16 * (idx - 2) +: 16];
				end
				default: ;
			endcase
			r.ev_new = (idx == 1 && s.cmd inside {cmd_kbd, cmd_osd, cmd_mouse}) ||
				(idx == 2 && s.cmd == cmd_mouse);
		end
		return r;
	endfunction

	function automatic string test_name(int id);
		case (id)
			1: return "buttons and joysticks";
			2: return "rtc";
			3: return "events";
			4: return "back-pressure";
			5: return "video readback";
			default: return "unnamed";
		endcase
	endfunction

	task automatic compare(input string name, input logic [63:0] got_v, input logic [63:0] exp_v);
		if (got_v !== exp_v) begin
			$display("Fail at %0t ns: %s = %h, expected %h", $time, name, got_v, exp_v);
			err_test++;
			err_total++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			st = '0;
			idx = 0;
			level = 1'b0;
			exp_q.delete();
		end else begin
			// outputs now reflect every strobe before this edge
			compare("joy0", joy0, st.joy0);
			compare("joy1", joy1, st.joy1);
			compare("buttons", buttons, st.buttons);
			compare("conf", conf, st.conf);
			compare("mouse_buttons", mouse_buttons, st.mouse_buttons);
			compare("rtc", rtc, st.rtc);
			compare("io_dout", io_dout, st.dout);
			if (kbd_strobe) begin
				level = ~level;
				if (exp_q.size() == 0) begin
					$display("unexpected kbd_strobe at %0t ns with no event outstanding", $time);
					err_test++;
					err_total++;
				end else begin
					got = exp_q.pop_front();
					compare("kbd_type", kbd_type, got.kind);
					compare("kbd_data", kbd_data, got.data);
				end
			end
			compare("kbd_level", kbd_level, level);
			if (!io_ena) begin
				idx = 0;
			end else if (io_strobe) begin
				st = apply_word(st, idx, io_din, exp_vid);
				if (st.ev_new)
					exp_q.push_back(st.ev);
				if (idx < 15)
					idx++;
			end
		end
		if (test_end) begin
			bad = err_test + wait_fails - fails_seen;
			tests_run++;
			if (bad != 0)
				tests_bad++;
			if (bad == 0)
				$display("test %0d %s: ok", test_id, test_name(test_id));
			else
				$display("test %0d %s: %0d failures", test_id, test_name(test_id), bad);
			err_test = 0;
			fails_seen = wait_fails;
		end
		if (done)
			$display("%0d tests, %0d failed, %0d mismatches, %0d timeouts",
				tests_run, tests_bad, err_total, wait_fails);
		pending <= exp_q.size();
		errors  <= err_total;
	end

endmodule

/* tests/tb_hps_io.sv */
`timescale 1ns/100ps

module tb_hps_io
	import hps_io_pkg::*;
();

	localparam int wait_limit = 2000; // cycles per wait loop

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        io_ena = 1'b0;
	logic        io_strobe = 1'b0;
	logic [15:0] io_din = '0;
	logic        kbd_hold = 1'b0;
	logic        ce_pix = 1'b0;
	logic        de = 1'b0;
	logic        hs = 1'b0;
	logic        vs = 1'b0;
	logic [15:0] io_dout;
	logic        io_wait;
	logic [15:0] joy0;
	logic [15:0] joy1;
	logic [1:0]  buttons;
	logic [3:0]  conf;
	logic [2:0]  mouse_buttons;
	logic        kbd_strobe;
	logic        kbd_level;
	ev_kind_t    kbd_type;
	logic [7:0]  kbd_data;
	logic [63:0] rtc;

	vid_info_t   exp_vid = '0;
	logic        test_end = 1'b0;
	int          test_id = 0;
	logic        done = 1'b0;
	int          wait_fails = 0;
	int          errors;
	int          pending;

	logic [31:0] lfsr = 32'h4bbd_198b;
	logic [15:0] words[$]; // next host transfer

	logic        big = 1'b0; // raster size requested by the test
	logic        cur_big = 1'b0;
	int          hpos = 0;
	int          vpos = 0;
	int          htot;
	int          hact;
	int          vtot;
	int          vact;

	hps_io_top DUT (.*);
	hps_io_checker u_check (.*);

	initial forever #50 clk = ~clk;

	always_comb begin
		htot = cur_big ? 24 : 20;
		hact = cur_big ? 16 : 12;
		vtot = cur_big ? 12 : 10;
		vact = cur_big ? 8 : 6;
	end

	// raster at two clocks per pixel, size switches only at frame start
	always @(posedge clk) begin
		if (rst) begin
			ce_pix <= 1'b0;
			de <= 1'b0;
			hs <= 1'b0;
			vs <= 1'b0;
			hpos = 0;
			vpos = 0;
		end else begin
			ce_pix <= ~ce_pix;
			if (ce_pix) begin
				if (hpos != htot - 1) begin
					hpos++;
				end else begin
					hpos = 0;
					if (vpos != vtot - 1) begin
						vpos++;
					end else begin
						vpos = 0;
						cur_big = big;
					end
				end
				de <= hpos < hact && vpos < vact;
				hs <= hpos >= hact + 2 && hpos <= hact + 3;
				vs <= vpos == vtot - 2; // one line of vsync
			end
		end
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	function automatic logic [15:0] rand16();
		logic [15:0] v;
		int          i;
		for (i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	// host bus, one strobe per word, never while io_wait is up
	task automatic send_transfer();
		int n;
		@(posedge clk);
		io_ena <= 1'b1;
		foreach (words[i]) begin
			@(posedge clk);
			n = 0;
			while (io_wait && n < wait_limit) begin
				@(posedge clk);
				n++;
			end
			if (io_wait) begin
				$display("io_wait stuck high at %0t ns, host could not send", $time);
				wait_fails++;
			end
			io_strobe <= 1'b1;
			io_din <= words[i];
			@(posedge clk);
			io_strobe <= 1'b0;
		end
		@(posedge clk);
		io_ena <= 1'b0;
		words.delete();
	endtask

	task automatic send_random(input logic [7:0] c, input int n);
		words.push_back({8'h00, c});
		repeat (n) words.push_back(rand16());
		send_transfer();
	endtask

	task automatic wait_events();
		int n;
		n = 0;
		while (pending != 0 && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (pending != 0) begin
			$display("%0d events never reached kbd_strobe", pending);
			wait_fails++;
		end
	endtask

	task automatic wait_frames(input int k);
		int   seen;
		int   n;
		logic prev;
		seen = 0;
		n = 0;
		prev = vs;
		while (seen < k && n < 1000 * k) begin
			@(posedge clk);
			if (prev && !vs)
				seen++;
			prev = vs;
			n++;
		end
		if (seen < k) begin
			$display("only %0d of %0d frames seen before timeout", seen, k);
			wait_fails++;
		end
	endtask

	task automatic release_after_wait();
		int n;
		n = 0;
		while (!io_wait && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (!io_wait) begin
			$display("io_wait never rose while the event FIFO was full");
			wait_fails++;
		end
		repeat (20) @(posedge clk);
		kbd_hold <= 1'b0;
	endtask

	task automatic set_expected_vid(input logic [7:0] n);
		exp_vid <= '{nres: n, hcnt: 32'(hact), vcnt: 32'(vact),
			htime: 32'(2 * htot), vtime: 32'(2 * htot * vtot)};
	endtask

	task automatic end_test(input int id);
		@(posedge clk);
		test_id <= id;
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	initial begin
		int r;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (r = 0; r < 4; r++) begin
			send_random(cmd_buttons, 1);
			send_random(cmd_joy0, 1);
			send_random(cmd_joy1, 1);
		end
		end_test(1);
		for (r = 0; r < 3; r++)
			send_random(cmd_rtc, 4);
		end_test(2);
		for (r = 0; r < 3; r++) begin
			send_random(cmd_kbd, 1);
			send_random(cmd_osd, 1);
			send_random(cmd_mouse, 3);
		end
		wait_events();
		end_test(3);
		kbd_hold <= 1'b1; // core stalls, events pile up
		fork
			for (r = 0; r < fifo_depth + 3; r++)
				send_random(cmd_kbd, 1);
			release_after_wait();
		join
		wait_events();
		end_test(4);
		wait_frames(3);
		set_expected_vid(8'd1);
		send_random(cmd_vid_info, 9);
		big <= 1'b1;
		wait_frames(4);
		set_expected_vid(8'd2); // one more resolution change
		send_random(cmd_vid_info, 9);
		end_test(5);
		@(posedge clk);
		done <= 1'b1;
		@(posedge clk);
		done <= 1'b0;
		repeat (2) @(posedge clk);
		if (errors == 0 && wait_fails == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#5_000_000;
		$display("simulation ran too long and was stopped");
		$display("Verification failed");
		$finish;
	end

endmodule
